/* filelist.f */
synth_pkg.sv
synth_param_regs.sv
harmonic_phase.sv
harmonic_level.sv
scaling_accumulator.sv
harmonic_sequencer.sv
dac_serializer.sv
additive_synth_top.sv
tb_additive_synth.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_additive_synth -Mdir obj_dir -o sim_additive_synth

./obj_dir/sim_additive_synth | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

/* tb_additive_synth.sv */
`default_nettype none

module tb_additive_synth import synth_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DELAY = 2;               // Inputs change this long after the rising edge
	localparam int FRAME_TOTAL = 16;              // Frames captured over all tests
	localparam int WATCHDOG_TIME = (FRAME_TOTAL + 3) * SAMPLE_INTERVAL * CLK_PERIOD;

	logic ADC_Data_Received;
	logic reset;
	logic i_param_load;
	phase_t i_param_freq;
	level_t i_param_rate;
	level_t i_param_initial;
	phase_t i_param_spread;
	logic o_dac_cs;
	logic o_dac_clock;
	logic o_dac_bit;

	phase_t model_phase [NUM_HARMONICS];          // Reference copy of every partial's phase
	phase_t snap_freq;                            // Parameters used by the walk now running
	phase_t snap_spread;
	level_t snap_rate;
	level_t snap_initial;
	phase_t live_freq;                            // Last loaded parameters
	phase_t live_spread;
	level_t live_rate;
	level_t live_initial;
	int errors;
	int checks;
	int tests;
	int failed_tests;
	int clock_pulses;
	time prev_fall;
	logic [31:0] lcg_state;

	additive_synth_top u_additive_synth_top (
		.ADC_Data_Received(ADC_Data_Received), .reset(reset),
		.i_param_load(i_param_load), .i_param_freq(i_param_freq), .i_param_rate(i_param_rate),
		.i_param_initial(i_param_initial), .i_param_spread(i_param_spread),
		.o_dac_cs(o_dac_cs), .o_dac_clock(o_dac_clock), .o_dac_bit(o_dac_bit));

	initial begin
		ADC_Data_Received = 1'b0;
		forever #(CLK_PERIOD / 2) ADC_Data_Received = ~ADC_Data_Received;
	end

	// Counts SPI clock pulses, cleared at the start of each frame
	always @(posedge o_dac_clock)
		clock_pulses++;

	// Outside a frame the SPI clock must rest low
	always @(negedge ADC_Data_Received) begin
		if (!reset && o_dac_cs === 1'b1 && o_dac_clock !== 1'b0) begin
			$display("Failure at %0t: the SPI clock moved while chip select was high", $time);
			errors++;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic sample_t scale_to_dac(input int total);
		int scaled;
		scaled = total >>> OUT_SHIFT;                // Arithmetic, so negative totals round down
		if (scaled > SAMPLE_MAX)
			scaled = SAMPLE_MAX;
		else if (scaled < -SAMPLE_MAX)
			scaled = -SAMPLE_MAX;
		return sample_t'(scaled);
	endfunction

	task automatic check_sample(input sample_t got, input sample_t expected, input string what);
		checks++;
		if (got !== expected) begin
			$display("** Error at %0t: %s, got %0d, expected %0d", $time, what, got, expected);
			errors++;
		end
	endtask

	task automatic check_count(input harmonic_t got, input harmonic_t expected, input string what);
		checks++;
		if (got !== expected) begin
			$display("** Error at %0t: %s, got %0d, expected %0d", $time, what, got, expected);
			errors++;
		end
	endtask

	task automatic check_cycles(input int got, input int expected, input string what);
		checks++;
		if (got != expected) begin
			$display("** Error at %0t: %s, got %0d cycles, expected %0d", $time, what, got,
				expected);
			errors++;
		end
	endtask

	// One sample's walk over the harmonics, as the rules describe it
	task automatic model_walk(output sample_t exp_left, output sample_t exp_right);
		int k;
		int total_left;
		int total_right;
		int level;
		int x;
		int magnitude;
		int partial;
		int product;
		phase_t advance;
		logic stop;
		total_left = 0;
		total_right = 0;
		level = int'(snap_initial);                  // Harmonic 0 takes the starting level
		stop = 1'b0;
		for (k = 0; k < NUM_HARMONICS && !stop; k++) begin
			advance = phase_t'(int'(snap_freq) * (k + 1) + int'(snap_spread) * k);
			x = int'(model_phase[k][14:0]);
			magnitude = (x * (32768 - x)) >>> SINE_SHIFT;
			if (magnitude > SAMPLE_MAX)
				magnitude = SAMPLE_MAX;
			partial = model_phase[k][15] ? -magnitude : magnitude;
			product = (partial * level) >>> LEVEL_BITS;   // Floor, also for negative partials
			if (k % 2 == 0)
				total_left += product;
			else
				total_right += product;
			model_phase[k] = model_phase[k] + advance;
			stop = advance[15];                      // Half a cycle or more ends the walk here
			level = (level * int'(snap_rate)) >>> LEVEL_BITS;
		end
		exp_left = scale_to_dac(total_left);
		exp_right = scale_to_dac(total_right);
	endtask

	task automatic capture_frame(output sample_t left, output sample_t right, output int gap);
		logic [FRAME_BITS-1:0] word;
		time fall;
		int i;
		@(negedge o_dac_cs);
		fall = $time;
		clock_pulses = 0;
		gap = int'((fall - prev_fall) / CLK_PERIOD);
		prev_fall = fall;
		word = '0;
		for (i = 0; i < FRAME_BITS; i++) begin
			@(posedge o_dac_clock);
			#1;                                        // Bit is held for the whole clock-high half
			word = {word[FRAME_BITS-2:0], o_dac_bit};
		end
		@(posedge o_dac_cs);
		#1;
		left = sample_t'(word[31:16]);              // Left sample goes out first
		right = sample_t'(word[15:0]);
	endtask

	// Predicts a frame, moves the model to the new snapshot, then captures the frame
	task automatic run_frame(input string name);
		sample_t exp_left;
		sample_t exp_right;
		sample_t got_left;
		sample_t got_right;
		int gap;
		model_walk(exp_left, exp_right);
		snap_freq = live_freq;                       // Snapshot is taken at the coming frame start
		snap_spread = live_spread;
		snap_rate = live_rate;
		snap_initial = live_initial;
		capture_frame(got_left, got_right, gap);
		check_cycles(gap, SAMPLE_INTERVAL, {name, " frame start spacing"});
		check_count(harmonic_t'(clock_pulses), harmonic_t'(FRAME_BITS),
			{name, " SPI clock pulses"});
		check_sample(got_left, exp_left, {name, " left sample"});
		check_sample(got_right, exp_right, {name, " right sample"});
	endtask

	task automatic apply_load(input phase_t freq, input level_t rate, input level_t init_level,
		input phase_t spread);
		@(negedge o_dac_cs);                         // A new walk starts with this frame
		repeat (2) @(posedge ADC_Data_Received);   // Lands while that walk is running
		#DRIVE_DELAY;
		i_param_load = 1'b1;
		i_param_freq = freq;
		i_param_rate = rate;
		i_param_initial = init_level;
		i_param_spread = spread;
		@(posedge ADC_Data_Received);
		#DRIVE_DELAY;
		i_param_load = 1'b0;
		live_freq = freq;
		live_rate = rate;
		live_initial = init_level;
		live_spread = spread;
	endtask

	task automatic reset_dut;
		int k;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge ADC_Data_Received);
		#DRIVE_DELAY;
		reset = 1'b0;
		@(posedge ADC_Data_Received);
		prev_fall = $time;                           // First edge with reset low starts the timer
		for (k = 0; k < NUM_HARMONICS; k++)
			model_phase[k] = '0;
		snap_freq = phase_t'(FREQ_DEFAULT);
		snap_spread = phase_t'(SPREAD_DEFAULT);
		snap_rate = level_t'(RATE_DEFAULT);
		snap_initial = level_t'(INITIAL_DEFAULT);
		live_freq = snap_freq;
		live_spread = snap_spread;
		live_rate = snap_rate;
		live_initial = snap_initial;
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests++;
		if (errors == start_errors) begin
			$display("%s: ok", name);
		end else begin
			failed_tests++;
			$display("%s: %0d errors", name, errors - start_errors);
		end
	endtask

	task automatic test_reset_idle;
		int start_errors;
		start_errors = errors;
		run_frame("reset_idle");                     // Spacing here is measured from reset release
		report_test("reset_idle", start_errors);
	endtask

	task automatic test_frame_timing;
		int start_errors;
		start_errors = errors;
		run_frame("frame_timing");
		run_frame("frame_timing");
		report_test("frame_timing", start_errors);
	endtask

	task automatic test_default_params;
		int start_errors;
		start_errors = errors;
		run_frame("default_params");
		report_test("default_params", start_errors);
	endtask

	task automatic test_static_phase;
		int start_errors;
		start_errors = errors;
		fork
			run_frame("static_phase");
			apply_load(16'd0, 9'd400, 9'd300, 16'd0);
		join
		run_frame("static_phase");                   // Walk under the load kept the old snapshot
		run_frame("static_phase");
		run_frame("static_phase");
		report_test("static_phase", start_errors);
	endtask

	task automatic test_limit_flag;
		int start_errors;
		start_errors = errors;
		// Harmonic 1 advances by 40000, so the walk ends after it
		fork
			run_frame("limit_flag");
			apply_load(16'd20000, 9'd480, 9'd500, 16'd0);
		join
		run_frame("limit_flag");
		run_frame("limit_flag");
		report_test("limit_flag", start_errors);
	endtask

	task automatic test_random_loads;
		int start_errors;
		int round;
		phase_t freq;
		phase_t spread;
		level_t rate;
		level_t init_level;
		start_errors = errors;
		for (round = 0; round < 3; round++) begin
			lcg_state = lcg_next(lcg_state);
			freq = {5'd0, lcg_state[26:16]};
			lcg_state = lcg_next(lcg_state);
			spread = {6'd0, lcg_state[25:16]};
			lcg_state = lcg_next(lcg_state);
			rate = lcg_state[24:16] | 9'h100;          // Keeps the roll-off slow
			lcg_state = lcg_next(lcg_state);
			init_level = lcg_state[24:16] | 9'h180;
			fork
				run_frame("random_loads");
				apply_load(freq, rate, init_level, spread);
			join
		end
		run_frame("random_loads");
		run_frame("random_loads");
		report_test("random_loads", start_errors);
	endtask

	initial begin
		#(WATCHDOG_TIME);
		$display("Timeout: the DUT stopped sending frames before the tests ended");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		reset = 1'b1;
		i_param_load = 1'b0;
		i_param_freq = '0;
		i_param_rate = '0;
		i_param_initial = '0;
		i_param_spread = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		failed_tests = 0;
		clock_pulses = 0;
		lcg_state = 32'h5ba3;
		reset_dut();
		test_reset_idle();
		test_frame_timing();
		test_default_params();
		test_static_phase();
		test_limit_flag();
		test_random_loads();
		$display("Tests: %0d, failed tests: %0d, checks: %0d, errors: %0d", tests, failed_tests,
			checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* additive_synth_top.sv */
`default_nettype none

module additive_synth_top import synth_pkg::*; (
	input wire ADC_Data_Received,
	input wire reset,
	input wire i_param_load,
	input wire phase_t i_param_freq,
	input wire level_t i_param_rate,
	input wire level_t i_param_initial,
	input wire phase_t i_param_spread,
	output logic o_dac_cs,
	output logic o_dac_clock,
	output logic o_dac_bit
);

	phase_t freq;                                 // Snapshot of the parameters for this sample
	level_t rate;
	level_t initial_level;
	phase_t spread;
	logic snapshot;
	logic request;
	harmonic_t harmonic;
	sample_t partial;
	logic partial_valid;
	logic too_high;
	logic level_restart;
	logic level_step;
	level_t level;
	logic start_left;
	logic start_right;
	logic busy_left;
	logic busy_right;
	logic acc_clear;
	total_t total_left;
	total_t total_right;
	logic dac_start;

	synth_param_regs u_synth_param_regs (
		.ADC_Data_Received(ADC_Data_Received), .reset(reset),
		.i_param_load(i_param_load), .i_param_freq(i_param_freq), .i_param_rate(i_param_rate),
		.i_param_initial(i_param_initial), .i_param_spread(i_param_spread),
		.i_snapshot(snapshot), .o_freq(freq), .o_rate(rate), .o_initial(initial_level),
		.o_spread(spread));

	harmonic_phase u_harmonic_phase (
		.ADC_Data_Received(ADC_Data_Received), .reset(reset),
		.i_request(request), .i_harmonic(harmonic), .i_freq(freq), .i_spread(spread),
		.o_partial(partial), .o_partial_valid(partial_valid), .o_too_high(too_high));

	harmonic_level u_harmonic_level (
		.ADC_Data_Received(ADC_Data_Received), .reset(reset),
		.i_restart(level_restart), .i_step(level_step), .i_initial(initial_level),
		.i_rate(rate), .o_level(level));

	harmonic_sequencer u_harmonic_sequencer (
		.ADC_Data_Received(ADC_Data_Received), .reset(reset),
		.i_partial_valid(partial_valid), .i_too_high(too_high),
		.i_busy_left(busy_left), .i_busy_right(busy_right), .o_snapshot(snapshot),
		.o_request(request), .o_harmonic(harmonic), .o_level_restart(level_restart),
		.o_level_step(level_step), .o_start_left(start_left), .o_start_right(start_right),
		.o_clear(acc_clear), .o_dac_start(dac_start));

	// Even harmonics feed the left channel and odd ones the right
	scaling_accumulator u_acc_left (
		.ADC_Data_Received(ADC_Data_Received), .reset(reset),
		.i_start(start_left), .i_clear(acc_clear), .i_partial(partial), .i_level(level),
		.o_total(total_left), .o_busy(busy_left));

	scaling_accumulator u_acc_right (
		.ADC_Data_Received(ADC_Data_Received), .reset(reset),
		.i_start(start_right), .i_clear(acc_clear), .i_partial(partial), .i_level(level),
		.o_total(total_right), .o_busy(busy_right));

	dac_serializer u_dac_serializer (
		.ADC_Data_Received(ADC_Data_Received), .reset(reset),
		.i_start(dac_start), .i_total_left(total_left), .i_total_right(total_right),
		.o_dac_cs(o_dac_cs), .o_dac_clock(o_dac_clock), .o_dac_bit(o_dac_bit));

endmodule

`default_nettype wire

/* dac_serializer.sv */
`default_nettype none

module dac_serializer import synth_pkg::*; (
	input wire ADC_Data_Received,
	input wire reset,
	input wire i_start,                           // Totals are taken in this cycle
	input wire total_t i_total_left,
	input wire total_t i_total_right,
	output logic o_dac_cs,                        // Low for the whole 64-cycle frame
	output logic o_dac_clock,
	output logic o_dac_bit
);

	logic [FRAME_BITS-1:0] r_shift;               // Left sample in the upper half
	logic [FRAME_COUNT_BITS-1:0] r_count;         // Even counts have the SPI clock low
	logic r_active;

	// Clip to a symmetric range so both channels swing equally
	function automatic sample_t saturate(input total_t total);
		total_t scaled;
		scaled = total >>> OUT_SHIFT;
		if (scaled > total_t'(SAMPLE_MAX))
			return sample_t'(SAMPLE_MAX);
		else if (scaled < -total_t'(SAMPLE_MAX))
			return -sample_t'(SAMPLE_MAX);
		return scaled[15:0];
	endfunction

	always_ff @(posedge ADC_Data_Received) begin
		if (reset) begin
			o_dac_cs <= 1'b1;
			o_dac_clock <= 1'b0;
			o_dac_bit <= 1'b0;
			r_count <= '0;
			r_active <= 1'b0;
		end else if (i_start) begin
			r_shift <= {saturate(i_total_left), saturate(i_total_right)};
			o_dac_bit <= saturate(i_total_left) >= 0 ? 1'b0 : 1'b1;   // Sign bit leads
			o_dac_cs <= 1'b0;
			o_dac_clock <= 1'b0;
			r_count <= '0;
			r_active <= 1'b1;
		end else if (r_active) begin
			r_count <= r_count + 1'b1;
			if (!r_count[0]) begin
				o_dac_clock <= 1'b1;                   // DAC samples the bit on this edge
			end else if (r_count == FRAME_COUNT_BITS'(2 * FRAME_BITS - 1)) begin
				o_dac_clock <= 1'b0;
				o_dac_cs <= 1'b1;
				o_dac_bit <= 1'b0;
				r_active <= 1'b0;
			end else begin
				o_dac_clock <= 1'b0;
				o_dac_bit <= r_shift[FRAME_BITS-2]; // Next bit while the clock is low
				r_shift <= r_shift << 1;
			end
		end
	end

	// Frames are 64 cycles long and the sample tick is far slower
	a_no_start_active: assert property (@(posedge ADC_Data_Received) disable iff (reset)
		i_start |-> !r_active);

endmodule

`default_nettype wire

/* harmonic_sequencer.sv */
`default_nettype none

module harmonic_sequencer import synth_pkg::*; (
	input wire ADC_Data_Received,
	input wire reset,
	input wire i_partial_valid,
	input wire i_too_high,                        // Valid with the partial, held after it
	input wire i_busy_left,
	input wire i_busy_right,
	output logic o_snapshot,
	output logic o_request,
	output harmonic_t o_harmonic,
	output logic o_level_restart,
	output logic o_level_step,
	output logic o_start_left,                    // Even harmonics
	output logic o_start_right,                   // Odd harmonics
	output logic o_clear,
	output logic o_dac_start
);

	seq_state_t r_state;
	logic [TIMER_BITS-1:0] r_timer;               // Free-running sample period counter
	logic w_tick;
	logic w_free;                                 // Accumulator for this harmonic is idle
	logic w_last;                                 // This harmonic ends the walk

	assign w_tick = (r_timer == TIMER_BITS'(SAMPLE_INTERVAL - 1));
	assign w_free = o_harmonic[0] ? !i_busy_right : !i_busy_left;
	assign w_last = i_too_high || (o_harmonic == harmonic_t'(NUM_HARMONICS - 1));

	// The frame launch, the clear and the snapshot share one cycle
	assign o_dac_start = (r_state == seq_idle);
	assign o_clear = (r_state == seq_idle);
	assign o_snapshot = (r_state == seq_idle);
	assign o_level_restart = (r_state == seq_latch);
	assign o_level_step = (r_state == seq_level_step);
	assign o_request = (r_state == seq_latch) || (r_state == seq_level_step);
	assign o_start_left = (r_state == seq_start_add) && !o_harmonic[0] && !i_busy_left;
	assign o_start_right = (r_state == seq_start_add) && o_harmonic[0] && !i_busy_right;

	always_ff @(posedge ADC_Data_Received) begin
		if (reset) begin
			r_timer <= '0;
			r_state <= seq_clear;                    // First walk runs on the reset snapshot
			o_harmonic <= '0;
		end else begin
			r_timer <= w_tick ? '0 : r_timer + 1'b1;
			case (r_state)
				seq_idle: r_state <= seq_clear;       // Snapshot is taken at the end of this cycle
				seq_clear: begin
					o_harmonic <= '0;
					r_state <= seq_latch;
				end
				seq_latch: r_state <= seq_wait_part;
				seq_level_step: r_state <= seq_wait_part;
				seq_wait_part: begin
					if (i_partial_valid)
						r_state <= seq_start_add;
				end
				seq_start_add: begin
					if (w_free) begin
						if (w_last) begin
							r_state <= seq_drain;        // A too-high harmonic is still summed
						end else begin
							o_harmonic <= o_harmonic + 1'b1;
							r_state <= seq_level_step;
						end
					end
				end
				seq_drain: begin
					// Busy is already up for a start issued in the previous cycle
					if (!i_busy_left && !i_busy_right)
						r_state <= seq_wait_tick;
				end
				seq_wait_tick: begin
					if (w_tick)
						r_state <= seq_idle;
				end
				default: r_state <= seq_clear;
			endcase
		end
	end

endmodule

`default_nettype wire

/* scaling_accumulator.sv */
`default_nettype none

module scaling_accumulator import synth_pkg::*; (
	input wire ADC_Data_Received,
	input wire reset,
	input wire i_start,                           // Take one partial and its level
	input wire i_clear,                           // Zero the total for a new sample
	input wire sample_t i_partial,
	input wire level_t i_level,
	output total_t o_total,
	output logic o_busy                           // LEVEL_BITS multiply cycles plus one add
);

	total_t r_multiplicand;                       // Partial, doubled on every step
	level_t r_multiplier;                         // Level, consumed from the LSB up
	total_t r_product;
	logic [STEP_BITS-1:0] r_step;

	always_ff @(posedge ADC_Data_Received) begin
		if (reset) begin
			o_total <= '0;
			o_busy <= 1'b0;
			r_step <= '0;
		end else begin
			if (i_clear)
				o_total <= '0;
			if (i_start) begin
				r_multiplicand <= total_t'(i_partial);   // Sign extended
				r_multiplier <= i_level;
				r_product <= '0;
				r_step <= '0;
				o_busy <= 1'b1;
			end else if (o_busy) begin
				r_step <= r_step + 1'b1;
				if (r_step < STEP_BITS'(LEVEL_BITS)) begin
					if (r_multiplier[0])
						r_product <= r_product + r_multiplicand;
					r_multiplicand <= r_multiplicand <<< 1;
					r_multiplier <= r_multiplier >> 1;
				end else begin
					// Floor division by 512 keeps the sign of the partial
					o_total <= o_total + (r_product >>> LEVEL_BITS);
					o_busy <= 1'b0;
				end
			end
		end
	end

	// The sequencer waits for this channel to be free before it starts it again
	a_no_start_busy: assert property (@(posedge ADC_Data_Received) disable iff (reset)
		i_start |-> !o_busy);

endmodule

`default_nettype wire

/* harmonic_level.sv */
`default_nettype none

module harmonic_level import synth_pkg::*; (
	input wire ADC_Data_Received,
	input wire reset,
	input wire i_restart,                         // Harmonic 0 of a new sample
	input wire i_step,                            // Move on to the next harmonic
	input wire level_t i_initial,
	input wire level_t i_rate,                    // Ratio between neighbouring harmonics
	output level_t o_level
);

	logic [2*LEVEL_BITS-1:0] w_product;

	// Full-width product so the shift keeps the top bits
	assign w_product = o_level * i_rate;

	always_ff @(posedge ADC_Data_Received) begin
		if (reset) begin
			o_level <= '0;
		end else if (i_restart) begin
			o_level <= i_initial;
		end else if (i_step) begin
			// A rate below 512 gives a geometric roll-off toward zero
			o_level <= w_product[2*LEVEL_BITS-1:LEVEL_BITS];
		end
	end

endmodule

`default_nettype wire

/* harmonic_phase.sv */
`default_nettype none

module harmonic_phase import synth_pkg::*; (
	input wire ADC_Data_Received,
	input wire reset,
	input wire i_request,                         // Pulse, one harmonic per cycle at most
	input wire harmonic_t i_harmonic,
	input wire phase_t i_freq,                    // Fundamental increment per sample
	input wire phase_t i_spread,                  // Extra increment per harmonic number
	output sample_t o_partial,
	output logic o_partial_valid,                 // Two cycles after the request
	output logic o_too_high                       // Advance reached half a cycle per sample
);

	phase_t phase_mem [NUM_HARMONICS];            // Current position of every partial
	phase_t r_phase;                              // Stage 1 holds the old phase and its advance
	phase_t r_advance;
	logic [INDEX_BITS-1:0] r_index;
	logic r_stage;
	phase_t w_advance;
	logic [14:0] w_x;
	logic [15:0] w_span;
	logic [31:0] w_product;
	logic [31:0] w_magnitude;
	sample_t w_shaped;

	always_comb begin
		// Harmonic k advances by freq*(k+1) + spread*k, wrapping at one full cycle
		w_advance = i_freq * (phase_t'(i_harmonic) + 16'd1) + i_spread * phase_t'(i_harmonic);

		// Parabola over each half cycle, x*(32768-x) peaks at 2^28
		w_x = r_phase[14:0];
		w_span = 16'd32768 - {1'b0, w_x};
		w_product = {17'd0, w_x} * {16'd0, w_span};
		w_magnitude = w_product >> SINE_SHIFT;
		if (w_magnitude > 32'(SAMPLE_MAX))
			w_magnitude = 32'(SAMPLE_MAX);           // Only the peak at x=16384 overflows
		w_shaped = r_phase[15] ? -sample_t'(w_magnitude[15:0]) : sample_t'(w_magnitude[15:0]);
	end

	always_ff @(posedge ADC_Data_Received) begin
		if (reset) begin
			for (int i = 0; i < NUM_HARMONICS; i++)
				phase_mem[i] <= '0;                    // All partials start at phase zero
			r_stage <= 1'b0;
			o_partial_valid <= 1'b0;
			o_too_high <= 1'b0;
		end else begin
			r_stage <= i_request;
			o_partial_valid <= r_stage;
			if (i_request) begin
				r_phase <= phase_mem[i_harmonic[INDEX_BITS-1:0]];
				r_advance <= w_advance;
				r_index <= i_harmonic[INDEX_BITS-1:0];
			end
			// The sequencer never asks for the same harmonic twice in a row, so no bypass
			if (r_stage) begin
				phase_mem[r_index] <= r_phase + r_advance;
				o_partial <= w_shaped;                 // Held until the next request returns
				o_too_high <= r_advance[15];
			end
		end
	end

endmodule

`default_nettype wire

/* synth_param_regs.sv */
`default_nettype none

module synth_param_regs import synth_pkg::*; (
	input wire ADC_Data_Received,
	input wire reset,
	input wire i_param_load,                      // One-cycle strobe for all four words
	input wire phase_t i_param_freq,
	input wire level_t i_param_rate,
	input wire level_t i_param_initial,
	input wire phase_t i_param_spread,
	input wire i_snapshot,                        // Start of a sample, from the sequencer
	output phase_t o_freq,
	output level_t o_rate,
	output level_t o_initial,
	output phase_t o_spread
);

	phase_t r_freq;                               // Live copies follow the load strobe
	level_t r_rate;
	level_t r_initial;
	phase_t r_spread;

	always_ff @(posedge ADC_Data_Received) begin
		if (reset) begin
			r_freq <= phase_t'(FREQ_DEFAULT);
			r_rate <= level_t'(RATE_DEFAULT);
			r_initial <= level_t'(INITIAL_DEFAULT);
			r_spread <= phase_t'(SPREAD_DEFAULT);
			o_freq <= phase_t'(FREQ_DEFAULT);         // Snapshot starts equal to the live set
			o_rate <= level_t'(RATE_DEFAULT);
			o_initial <= level_t'(INITIAL_DEFAULT);
			o_spread <= phase_t'(SPREAD_DEFAULT);
		end else begin
			if (i_param_load) begin
				r_freq <= i_param_freq;
				r_rate <= i_param_rate;
				r_initial <= i_param_initial;
				r_spread <= i_param_spread;
			end
			// A load in the same cycle as the snapshot lands in the next sample
			if (i_snapshot) begin
				o_freq <= r_freq;
				o_rate <= r_rate;
				o_initial <= r_initial;
				o_spread <= r_spread;
			end
		end
	end

endmodule

`default_nettype wire

/* synth_pkg.sv */
`default_nettype none

package synth_pkg;

	localparam int LEVEL_BITS = 9;                 // Level fraction is in units of 1/512
	localparam int NUM_HARMONICS = 16;             // Most partials summed per sample
	localparam int SAMPLE_INTERVAL = 1500;         // Clock cycles between DAC frames
	localparam int OUT_SHIFT = 4;                  // Totals are shifted down by this before saturation
	localparam int SINE_SHIFT = 13;                // Scales the parabola peak to the sample range
	localparam int FRAME_BITS = 32;                // Left and right samples in one SPI word
	localparam int SAMPLE_MAX = 32767;             // Symmetric clip level for partials and DAC words

	// Derived counter widths
	localparam int INDEX_BITS = $clog2(NUM_HARMONICS);
	localparam int TIMER_BITS = $clog2(SAMPLE_INTERVAL);
	localparam int STEP_BITS = $clog2(LEVEL_BITS + 1);
	localparam int FRAME_COUNT_BITS = $clog2(2 * FRAME_BITS);

	// Parameter values in force after reset
	localparam int FREQ_DEFAULT = 50;
	localparam int RATE_DEFAULT = 270;
	localparam int INITIAL_DEFAULT = 511;
	localparam int SPREAD_DEFAULT = 120;

	typedef logic [15:0] phase_t;                  // One full cycle of a partial
	typedef logic signed [15:0] sample_t;          // Partial or DAC sample
	typedef logic [LEVEL_BITS-1:0] level_t;        // Unsigned amplitude fraction
	typedef logic signed [31:0] total_t;           // Channel accumulator
	typedef logic [7:0] harmonic_t;                // Harmonic index, 0 is the fundamental

	typedef enum logic [2:0] {
		seq_idle,        // Frame launch, accumulator clear and parameter snapshot
		seq_level_step,  // Step the level and request the next harmonic
		seq_wait_part,   // Wait for the partial to come back
		seq_start_add,   // Hand the partial to a free accumulator
		seq_drain,       // Wait for both accumulators to finish
		seq_latch,       // Load the starting level and request harmonic 0
		seq_clear,       // Zero the harmonic index before a walk
		seq_wait_tick    // Hold the finished totals until the sample tick
	} seq_state_t;

endpackage

`default_nettype wire
